//--- bench/tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
	parameter int HALF_PERIOD  = 10,
	parameter int RESET_CYCLES = 2
) (
	output logic CLK,
	output logic nRST
);

	// free running clock
	initial begin
		CLK = 1'b0;
		forever #HALF_PERIOD CLK = ~CLK;
	end

	// reset held low for a few edges
	initial begin
		nRST = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK);
		nRST <= 1'b1;
	end

endmodule

`default_nettype wire

//--- bench/tb_dcache.sv
`timescale 1ns/100ps
`default_nettype none

module tb_dcache;
	import dcache_pkg::*;

	localparam int MEM_WORDS     = 256;
	localparam int WAIT_SLOTS    = 1024;
	localparam int TIMEOUT       = 200;
	localparam int FLUSH_TIMEOUT = 1000;

	logic  CLK;
	logic  nRST;
	logic  dmem_ren   = 1'b0;
	logic  dmem_wen   = 1'b0;
	word_t dmem_addr  = '0;
	word_t dmem_store = '0;
	word_t dmem_load;
	logic  dhit;
	logic  halt       = 1'b0;
	logic  flushed;
	logic  mem_ren;
	logic  mem_wen;
	word_t mem_addr;
	word_t mem_store;
	word_t mem_load   = '0;
	logic  mem_wait   = 1'b1;

	// memory behind the cache and last value written per word
	word_t      mem_model [MEM_WORDS];
	word_t      arch [MEM_WORDS];
	logic [1:0] wait_tab [WAIT_SLOTS];
	int         wait_ptr  = 0;
	logic [1:0] wait_left = '0;
	logic       seen_ren  = 1'b0;
	logic       seen_wen  = 1'b0;
	word_t      seen_addr = '0;
	word_t      seen_store = '0;

	integer seed        = 36;
	int     checks      = 0;
	int     errors      = 0;
	int     test_errors = 0;

	tb_clock #(.HALF_PERIOD(10), .RESET_CYCLES(2)) u_clock (
		.CLK  (CLK),
		.nRST (nRST)
	);

	dcache #(.WAYS(2)) UUT (
		.CLK        (CLK),
		.nRST       (nRST),
		.dmem_ren   (dmem_ren),
		.dmem_wen   (dmem_wen),
		.dmem_addr  (dmem_addr),
		.dmem_store (dmem_store),
		.dmem_load  (dmem_load),
		.dhit       (dhit),
		.halt       (halt),
		.flushed    (flushed),
		.mem_ren    (mem_ren),
		.mem_wen    (mem_wen),
		.mem_addr   (mem_addr),
		.mem_store  (mem_store),
		.mem_load   (mem_load),
		.mem_wait   (mem_wait)
	);

	// memory port seen mid cycle, answered on the next edge
	always @(negedge CLK) begin
		seen_ren   = mem_ren;
		seen_wen   = mem_wen;
		seen_addr  = mem_addr;
		seen_store = mem_store;
	end

	always @(posedge CLK) begin
		if (seen_ren || seen_wen) begin
			if (!mem_wait) begin
				// word moves at this edge
				if (seen_wen) begin
					mem_model[seen_addr[9:2]] <= seen_store;
				end
				mem_wait  <= 1'b1;
				wait_left <= wait_tab[wait_ptr];
				wait_ptr  <= (wait_ptr + 1) % WAIT_SLOTS;
			end else if (wait_left == 2'd0) begin
				mem_load <= mem_model[seen_addr[9:2]];
				mem_wait <= 1'b0;
			end else begin
				wait_left <= wait_left - 2'd1;
			end
		end
	end

	function automatic word_t fill_pattern(input int i);
		return word_t'(i) * 32'h9E37_79B9 + 32'h1234_5678;
	endfunction

	task automatic check_value(input string name, input word_t expected, input word_t actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("Error: %s expected %h, got %h", name, expected, actual);
		end
	endtask

	task automatic end_test(input string name);
		$display("test %s finished with %0d errors", name, errors - test_errors);
		test_errors = errors;
	endtask

	// one processor request, held until dhit
	task automatic access(input logic wr, input word_t addr, input word_t data,
			output word_t rdata, output logic first);
		int   n;
		logic done;
		@(posedge CLK);
		dmem_ren   <= !wr;
		dmem_wen   <= wr;
		dmem_addr  <= addr;
		dmem_store <= data;
		n     = 0;
		done  = 1'b0;
		rdata = '0;
		first = 1'b0;
		while (!done && n < TIMEOUT) begin
			@(negedge CLK);
			if (dhit) begin
				done  = 1'b1;
				rdata = dmem_load;
				first = (n == 0);
			end
			n++;
		end
		if (!done) begin
			errors++;
			$display("request to %h saw no dhit within %0d cycles", addr, TIMEOUT);
		end
		// completion edge
		@(posedge CLK);
		dmem_ren <= 1'b0;
		dmem_wen <= 1'b0;
		if (wr && done) begin
			arch[addr[9:2]] = data;
		end
	endtask

	initial begin
		word_t rd;
		word_t a;
		word_t d;
		logic  first;
		int    n;
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem_model[i] = fill_pattern(i);
			arch[i]      = fill_pattern(i);
		end
		for (int i = 0; i < WAIT_SLOTS; i++) begin
			wait_tab[i] = 2'($unsigned($random(seed)) % 4);
		end
		n = 0;
		while (!nRST && n < 10) begin
			@(posedge CLK);
			n++;
		end
		if (!nRST) begin
			errors++;
			$display("reset was never released");
		end
		@(negedge CLK);
		check_value("dhit", 0, dhit);
		check_value("mem_ren", 0, mem_ren);
		check_value("mem_wen", 0, mem_wen);
		check_value("flushed", 0, flushed);

		// first touch of a line misses
		access(1'b0, 32'h000, '0, rd, first);
		check_value("dhit", 0, first);
		check_value("dmem_load", arch[0], rd);
		end_test("cold_read");

		access(1'b1, 32'h000, 32'hCAFE_0001, rd, first);
		check_value("dhit", 1, first);
		access(1'b0, 32'h000, '0, rd, first);
		check_value("dhit", 1, first);
		check_value("dmem_load", 32'hCAFE_0001, rd);
		end_test("read_after_write");

		// three blocks of set 1, 64 bytes apart
		access(1'b0, 32'h008, '0, rd, first);
		access(1'b0, 32'h048, '0, rd, first);
		access(1'b1, 32'h008, 32'hB0B0_0001, rd, first);
		check_value("dhit", 1, first);
		access(1'b0, 32'h088, '0, rd, first);
		check_value("dhit", 0, first);
		check_value("dmem_load", arch[8'h22], rd);
		access(1'b0, 32'h008, '0, rd, first);
		check_value("dhit", 1, first);
		check_value("dmem_load", 32'hB0B0_0001, rd);
		access(1'b0, 32'h048, '0, rd, first);
		check_value("dhit", 0, first);
		// this one pushes out the dirty block
		access(1'b0, 32'h088, '0, rd, first);
		check_value("dhit", 0, first);
		check_value("mem_model[2]", arch[2], mem_model[2]);
		check_value("mem_model[3]", arch[3], mem_model[3]);
		end_test("eviction");

		for (int k = 0; k < 300; k++) begin
			a = ($unsigned($random(seed)) % 128) << 2;
			if ($random(seed) & 1) begin
				d = $random(seed);
				access(1'b1, a, d, rd, first);
			end else begin
				access(1'b0, a, '0, rd, first);
				check_value($sformatf("dmem_load@%h", a), arch[a[9:2]], rd);
			end
		end
		end_test("random_mix");

		@(posedge CLK);
		halt <= 1'b1;
		n = 0;
		while (!flushed && n < FLUSH_TIMEOUT) begin
			@(negedge CLK);
			n++;
		end
		if (!flushed) begin
			errors++;
			$display("flushed did not rise within %0d cycles", FLUSH_TIMEOUT);
		end
		for (int c = 0; c < 8; c++) begin
			@(negedge CLK);
			check_value("mem_ren", 0, mem_ren);
			check_value("mem_wen", 0, mem_wen);
		end
		for (int i = 0; i < MEM_WORDS; i++) begin
			check_value($sformatf("mem_model[%0d]", i), arch[i], mem_model[i]);
		end
		end_test("flush");

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
logic/dcache_pkg.sv
logic/way_if.sv
logic/dcache_way.sv
logic/way_select.sv
logic/dcache_ctrl.sv
logic/dcache.sv
bench/tb_clock.sv
bench/tb_dcache.sv

//--- logic/dcache.sv
`timescale 1ns/100ps
`default_nettype none

module dcache #(
	parameter int WAYS = 2,
	localparam int WAY_W = (WAYS > 1) ? $clog2(WAYS) : 1
) (
	input  wire                    CLK,
	input  wire                    nRST,
	input  wire                    dmem_ren,
	input  wire                    dmem_wen,
	input  wire dcache_pkg::word_t dmem_addr,
	input  wire dcache_pkg::word_t dmem_store,
	output dcache_pkg::word_t      dmem_load,
	output logic                   dhit,
	input  wire                    halt,
	output logic                   flushed,
	output logic                   mem_ren,
	output logic                   mem_wen,
	output dcache_pkg::word_t      mem_addr,
	output dcache_pkg::word_t      mem_store,
	input  wire dcache_pkg::word_t mem_load,
	input  wire                    mem_wait
);
	import dcache_pkg::*;

	logic             any_hit;
	logic [WAY_W-1:0] hit_way;
	logic [WAY_W-1:0] sel_way;
	logic [TAG_W-1:0] sel_tag;
	word_t            sel_data;

	way_if ways [WAYS] ();

	dcache_ctrl #(.WAYS(WAYS)) u_ctrl (
		.CLK        (CLK),
		.nRST       (nRST),
		.dmem_ren   (dmem_ren),
		.dmem_wen   (dmem_wen),
		.dmem_addr  (dmem_addr),
		.dmem_store (dmem_store),
		.dmem_load  (dmem_load),
		.dhit       (dhit),
		.halt       (halt),
		.flushed    (flushed),
		.mem_ren    (mem_ren),
		.mem_wen    (mem_wen),
		.mem_addr   (mem_addr),
		.mem_store  (mem_store),
		.mem_load   (mem_load),
		.mem_wait   (mem_wait),
		.ways       (ways),
		.any_hit    (any_hit),
		.hit_way    (hit_way),
		.sel_tag    (sel_tag),
		.sel_data   (sel_data),
		.sel_way    (sel_way)
	);

	for (genvar g = 0; g < WAYS; g++) begin : g_way
		dcache_way u_way (
			.CLK  (CLK),
			.nRST (nRST),
			.port (ways[g])
		);
	end

	way_select #(.WAYS(WAYS)) u_sel (
		.ways     (ways),
		.any_hit  (any_hit),
		.hit_way  (hit_way),
		.sel_tag  (sel_tag),
		.sel_data (sel_data),
		.sel_way  (sel_way)
	);

endmodule

`default_nettype wire

//--- logic/dcache_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_ctrl #(
	parameter int WAYS = 2,
	localparam int WAY_W = (WAYS > 1) ? $clog2(WAYS) : 1
) (
	input  wire                           CLK,
	input  wire                           nRST,
	input  wire                           dmem_ren,
	input  wire                           dmem_wen,
	input  wire dcache_pkg::word_t        dmem_addr,
	input  wire dcache_pkg::word_t        dmem_store,
	output dcache_pkg::word_t             dmem_load,
	output logic                          dhit,
	input  wire                           halt,
	output logic                          flushed,
	output logic                          mem_ren,
	output logic                          mem_wen,
	output dcache_pkg::word_t             mem_addr,
	output dcache_pkg::word_t             mem_store,
	input  wire dcache_pkg::word_t        mem_load,
	input  wire                           mem_wait,
	way_if.ctrl                           ways [WAYS],
	input  wire                           any_hit,
	input  wire [WAY_W-1:0]               hit_way,
	input  wire [dcache_pkg::TAG_W-1:0]   sel_tag,
	input  wire dcache_pkg::word_t        sel_data,
	output logic [WAY_W-1:0]              sel_way
);
	import dcache_pkg::*;

	localparam logic [2:0] IDLE   = 3'd0;
	localparam logic [2:0] WB     = 3'd1;
	localparam logic [2:0] REFILL = 3'd2;
	localparam logic [2:0] FLUSH  = 3'd3;
	localparam logic [2:0] DONE   = 3'd4;

	localparam logic [OFF_W-1:0] LAST_WORD = OFF_W'(WORDS_PER_BLK - 1);

	logic [2:0]       state_q, state_d;
	logic [OFF_W-1:0] word_q, word_d;
	logic [IDX_W-1:0] fl_set_q, fl_set_d;
	logic [WAY_W-1:0] fl_way_q, fl_way_d;
	logic [WAY_W-1:0] way_q, way_d;
	logic [WAY_W-1:0] mru_q [SETS];
	logic             mru_we;

	dcache_addr_u     req_a;
	dcache_addr_u     mem_a;
	logic             req;
	logic             line_done;
	logic [WAY_W-1:0] victim;

	logic [IDX_W-1:0] cmd_idx;
	logic [OFF_W-1:0] cmd_off;
	word_t            cmd_wdata;
	logic [WAYS-1:0]  valid_v;
	logic [WAYS-1:0]  dirty_v;
	logic [WAYS-1:0]  word_we_v;
	logic [WAYS-1:0]  fill_v;
	logic [WAYS-1:0]  mark_v;
	logic [WAYS-1:0]  inval_v;

	assign req_a.raw = dmem_addr;
	assign req       = dmem_ren | dmem_wen;

	// broadcast command, per-way strobes
	for (genvar g = 0; g < WAYS; g++) begin : g_way
		assign ways[g].idx        = cmd_idx;
		assign ways[g].off        = cmd_off;
		assign ways[g].tag        = req_a.f.tag;
		assign ways[g].wdata      = cmd_wdata;
		assign ways[g].word_we    = word_we_v[g];
		assign ways[g].fill_done  = fill_v[g];
		assign ways[g].mark_dirty = mark_v[g];
		assign ways[g].invalidate = inval_v[g];
		assign valid_v[g]         = ways[g].valid;
		assign dirty_v[g]         = ways[g].dirty;
	end

	// lowest invalid way, else the one after mru
	always_comb begin
		if (mru_q[req_a.f.idx] == WAY_W'(WAYS - 1)) begin
			victim = '0;
		end else begin
			victim = mru_q[req_a.f.idx] + 1'b1;
		end
		for (int w = WAYS - 1; w >= 0; w--) begin
			if (!valid_v[w]) begin
				victim = WAY_W'(w);
			end
		end
	end

	always_comb begin
		state_d   = state_q;
		word_d    = word_q;
		fl_set_d  = fl_set_q;
		fl_way_d  = fl_way_q;
		way_d     = way_q;
		mru_we    = 1'b0;
		line_done = 1'b0;
		cmd_idx   = req_a.f.idx;
		cmd_off   = req_a.f.off;
		cmd_wdata = dmem_store;
		sel_way   = way_q;
		word_we_v = '0;
		fill_v    = '0;
		mark_v    = '0;
		inval_v   = '0;
		dhit      = 1'b0;
		mem_ren   = 1'b0;
		mem_wen   = 1'b0;
		mem_a.f.tag      = req_a.f.tag;
		mem_a.f.idx      = req_a.f.idx;
		mem_a.f.off      = word_q;
		mem_a.f.byte_off = '0;

		case (state_q)
			IDLE: begin
				sel_way = hit_way;
				if (req && any_hit) begin
					dhit   = 1'b1;
					mru_we = 1'b1;
					if (dmem_wen) begin
						word_we_v[hit_way] = 1'b1;
						mark_v[hit_way]    = 1'b1;
					end
				end else if (halt) begin
					state_d  = FLUSH;
					word_d   = '0;
					fl_set_d = '0;
					fl_way_d = '0;
				end else if (req) begin
					way_d   = victim;
					word_d  = '0;
					state_d = (valid_v[victim] && dirty_v[victim]) ? WB : REFILL;
				end
			end
			WB: begin
				// victim line back to memory, old tag
				cmd_off     = word_q;
				mem_wen     = 1'b1;
				mem_a.f.tag = sel_tag;
				if (!mem_wait) begin
					word_d = word_q + 1'b1;
					if (word_q == LAST_WORD) begin
						word_d  = '0;
						state_d = REFILL;
					end
				end
			end
			REFILL: begin
				cmd_off   = word_q;
				cmd_wdata = mem_load;
				mem_ren   = 1'b1;
				if (!mem_wait) begin
					word_we_v[way_q] = 1'b1;
					word_d           = word_q + 1'b1;
					if (word_q == LAST_WORD) begin
						// retry from idle, now a hit
						fill_v[way_q] = 1'b1;
						word_d        = '0;
						state_d       = IDLE;
					end
				end
			end
			FLUSH: begin
				cmd_idx     = fl_set_q;
				cmd_off     = word_q;
				sel_way     = fl_way_q;
				mem_a.f.tag = sel_tag;
				mem_a.f.idx = fl_set_q;
				line_done   = 1'b1;
				if (valid_v[fl_way_q] && dirty_v[fl_way_q]) begin
					mem_wen   = 1'b1;
					line_done = !mem_wait && (word_q == LAST_WORD);
					if (!mem_wait) begin
						word_d = (word_q == LAST_WORD) ? '0 : word_q + 1'b1;
					end
				end
				// set order first, then way order
				if (line_done) begin
					inval_v[fl_way_q] = 1'b1;
					if (fl_way_q == WAY_W'(WAYS - 1)) begin
						fl_way_d = '0;
						fl_set_d = fl_set_q + 1'b1;
						if (fl_set_q == IDX_W'(SETS - 1)) begin
							state_d = DONE;
						end
					end else begin
						fl_way_d = fl_way_q + 1'b1;
					end
				end
			end
			DONE: begin
				state_d = DONE;
			end
			default: begin
				state_d = IDLE;
			end
		endcase
	end

	assign mem_addr  = mem_a.raw;
	assign mem_store = sel_data;
	assign dmem_load = sel_data;
	assign flushed   = (state_q == DONE);

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state_q  <= IDLE;
			word_q   <= '0;
			fl_set_q <= '0;
			fl_way_q <= '0;
			way_q    <= '0;
			mru_q    <= '{default: '0};
		end else begin
			state_q  <= state_d;
			word_q   <= word_d;
			fl_set_q <= fl_set_d;
			fl_way_q <= fl_way_d;
			way_q    <= way_d;
			if (mru_we) begin
				mru_q[req_a.f.idx] <= hit_way;
			end
		end
	end

	// memory port is one direction at a time
	assert property (@(posedge CLK) disable iff (!nRST) !(mem_ren && mem_wen));

	// held request while the memory stalls
	assert property (@(posedge CLK) disable iff (!nRST)
		(mem_wait && (mem_ren || mem_wen)) |=> $stable({mem_ren, mem_wen, mem_addr}));

endmodule

`default_nettype wire

//--- logic/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

	// one data or address word
	typedef logic [31:0] word_t;

	// cache geometry
	localparam int SETS          = 8;
	localparam int WORDS_PER_BLK = 2;
	localparam int IDX_W         = 3;
	localparam int OFF_W         = 1;
	localparam int BYTE_W        = 2;

	// whatever is left above index, offset and byte bits
	localparam int TAG_W = 32 - IDX_W - OFF_W - BYTE_W;

	// byte address, seen raw or split into its fields
	typedef union packed {
		word_t raw;
		struct packed {
			logic [TAG_W-1:0]  tag;
			logic [IDX_W-1:0]  idx;
			logic [OFF_W-1:0]  off;
			logic [BYTE_W-1:0] byte_off;
		} f;
	} dcache_addr_u;

endpackage

`default_nettype wire

//--- logic/dcache_way.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_way (
	input wire  CLK,
	input wire  nRST,
	way_if.way  port
);
	import dcache_pkg::*;

	logic [SETS-1:0]  valid_q;
	logic [SETS-1:0]  dirty_q;
	logic [TAG_W-1:0] tag_arr [SETS];
	word_t            data_arr [SETS][WORDS_PER_BLK];

	// combinational read of the addressed line
	assign port.valid = valid_q[port.idx];
	assign port.dirty = dirty_q[port.idx];
	assign port.tag_q = tag_arr[port.idx];
	assign port.rdata = data_arr[port.idx][port.off];
	assign port.hit   = valid_q[port.idx] && (tag_arr[port.idx] == port.tag);

	// line state
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			valid_q <= '0;
			dirty_q <= '0;
		end else begin
			if (port.invalidate) begin
				valid_q[port.idx] <= 1'b0;
				dirty_q[port.idx] <= 1'b0;
			end else if (port.fill_done) begin
				valid_q[port.idx] <= 1'b1;
				dirty_q[port.idx] <= 1'b0;
			end else if (port.mark_dirty) begin
				dirty_q[port.idx] <= 1'b1;
			end
		end
	end

	// tag and data storage
	always_ff @(posedge CLK) begin
		if (port.word_we) begin
			data_arr[port.idx][port.off] <= port.wdata;
		end
		if (port.fill_done) begin
			tag_arr[port.idx] <= port.tag;
		end
	end

	// refill end and flush never hit the same way together
	assert property (@(posedge CLK) disable iff (!nRST)
		!(port.fill_done && port.invalidate));

endmodule

`default_nettype wire

//--- logic/way_if.sv
`timescale 1ns/100ps
`default_nettype none

interface way_if;
	import dcache_pkg::*;

	// command from the controller, shared index/offset/tag
	logic [IDX_W-1:0] idx;
	logic [OFF_W-1:0] off;
	logic [TAG_W-1:0] tag;
	word_t            wdata;
	logic             word_we;
	logic             fill_done;
	logic             mark_dirty;
	logic             invalidate;

	// status of the addressed line
	logic             hit;
	logic             valid;
	logic             dirty;
	logic [TAG_W-1:0] tag_q;
	word_t            rdata;

	modport ctrl (
		output idx, off, tag, wdata, word_we, fill_done, mark_dirty, invalidate,
		input  valid, dirty
	);

	modport way (
		input  idx, off, tag, wdata, word_we, fill_done, mark_dirty, invalidate,
		output hit, valid, dirty, tag_q, rdata
	);

	modport sel (
		input hit, tag_q, rdata
	);

endinterface

`default_nettype wire

//--- logic/way_select.sv
`timescale 1ns/100ps
`default_nettype none

module way_select #(
	parameter int WAYS = 2,
	localparam int WAY_W = (WAYS > 1) ? $clog2(WAYS) : 1
) (
	way_if.sel                          ways [WAYS],
	output logic                        any_hit,
	output logic [WAY_W-1:0]            hit_way,
	output logic [dcache_pkg::TAG_W-1:0] sel_tag,
	output dcache_pkg::word_t           sel_data,
	input  wire [WAY_W-1:0]             sel_way
);
	import dcache_pkg::*;

	logic [WAYS-1:0]  hits;
	logic [TAG_W-1:0] tags [WAYS];
	word_t            datas [WAYS];

	for (genvar g = 0; g < WAYS; g++) begin : g_way
		assign hits[g]  = ways[g].hit;
		assign tags[g]  = ways[g].tag_q;
		assign datas[g] = ways[g].rdata;
	end

	// lowest hitting way wins
	always_comb begin
		hit_way = '0;
		for (int w = WAYS - 1; w >= 0; w--) begin
			if (hits[w]) begin
				hit_way = WAY_W'(w);
			end
		end
	end

	assign any_hit  = |hits;
	assign sel_tag  = tags[sel_way];
	assign sel_data = datas[sel_way];

	// a tag lives in one way of a set only
	always_comb begin
		assert #0 ($onehot0(hits));
	end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f filelist.f --top-module tb_dcache -o tb_dcache
./obj_dir/tb_dcache > sim.log 2>&1
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
exit 0
